//--- rvv_mulmac_pkg.sv
`default_nettype none

package rvv_mulmac_pkg;

  localparam int num_mul       = 2;
  localparam int sew           = 16;
  localparam int num_lanes     = 4;
  localparam int vlen          = sew * num_lanes;
  localparam int funct6_width  = 6;
  localparam int rob_idx_width = 4;

  // OPMVV funct6 encodings
  localparam logic [funct6_width-1:0] VMUL   = 6'b100101;
  localparam logic [funct6_width-1:0] VMULH  = 6'b100111;
  localparam logic [funct6_width-1:0] VMULHU = 6'b100100;
  localparam logic [funct6_width-1:0] VMACC  = 6'b101101;
  localparam logic [funct6_width-1:0] VNMSAC = 6'b101111;
  localparam logic [funct6_width-1:0] VMADD  = 6'b101001;
  localparam logic [funct6_width-1:0] VNMSUB = 6'b101011;

  typedef struct packed {
    logic [funct6_width-1:0]  funct6;
    logic [vlen-1:0]          vs1_data;
    logic [vlen-1:0]          vs2_data;
    // Old destination value
    logic [vlen-1:0]          vd_data;
    logic [rob_idx_width-1:0] rob_idx;
  } mul_rs_t;

  typedef struct packed {
    logic [rob_idx_width-1:0] rob_idx;
    logic [vlen-1:0]          w_data;
  } pu2rob_t;

  function automatic logic is_mac(input logic [funct6_width-1:0] funct6);
    case (funct6)
      VMACC, VNMSAC, VMADD, VNMSUB: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [sew-1:0] mul_lane(input logic [funct6_width-1:0] funct6,
                                              input logic [sew-1:0]          vs1,
                                              input logic [sew-1:0]          vs2);
    logic signed [2*sew-1:0] prod_s;
    logic [2*sew-1:0]        prod_u;
    prod_s = $signed({{sew{vs1[sew-1]}}, vs1}) * $signed({{sew{vs2[sew-1]}}, vs2});
    prod_u = {{sew{1'b0}}, vs1} * {{sew{1'b0}}, vs2};
    case (funct6)
      VMULH:   return prod_s[2*sew-1:sew];
      VMULHU:  return prod_u[2*sew-1:sew];
      default: return prod_u[sew-1:0];
    endcase
  endfunction

  // VMADD and VNMSUB multiply by the old destination instead of vs2
  function automatic logic mac_vd_is_mult(input logic [funct6_width-1:0] funct6);
    return (funct6 == VMADD) || (funct6 == VNMSUB);
  endfunction

  function automatic logic [sew-1:0] mac_product_lane(input logic [funct6_width-1:0] funct6,
                                                      input logic [sew-1:0] vs1,
                                                      input logic [sew-1:0] vs2,
                                                      input logic [sew-1:0] vd);
    logic [sew-1:0] mult;
    mult = mac_vd_is_mult(funct6) ? vd : vs2;
    return vs1 * mult;
  endfunction

  function automatic logic [sew-1:0] mac_addend_lane(input logic [funct6_width-1:0] funct6,
                                                     input logic [sew-1:0] vs2,
                                                     input logic [sew-1:0] vd);
    return mac_vd_is_mult(funct6) ? vs2 : vd;
  endfunction

  // Negated forms subtract the product from the addend
  function automatic logic [sew-1:0] mac_accum_lane(input logic [funct6_width-1:0] funct6,
                                                    input logic [sew-1:0] prod,
                                                    input logic [sew-1:0] addend);
    if ((funct6 == VNMSAC) || (funct6 == VNMSUB)) begin
      return addend - prod;
    end
    return addend + prod;
  endfunction

  function automatic logic [sew-1:0] mac_lane(input logic [funct6_width-1:0] funct6,
                                              input logic [sew-1:0] vs1,
                                              input logic [sew-1:0] vs2,
                                              input logic [sew-1:0] vd);
    return mac_accum_lane(funct6, mac_product_lane(funct6, vs1, vs2, vd),
                          mac_addend_lane(funct6, vs2, vd));
  endfunction

endpackage

`default_nettype wire

//--- rvv_mulmac_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rvv_mulmac_if #(
  parameter type payload_t = logic
) ();

  logic     valid;
  logic     ready;
  payload_t data;

  // Producer side
  modport src (
    output valid,
    output data,
    input  ready
  );

  // Consumer side
  modport dst (
    input  valid,
    input  data,
    output ready
  );

endinterface

`default_nettype wire

//--- rvv_mulmac_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_mulmac_dispatch (
  input  rvv_mulmac_pkg::mul_rs_t [rvv_mulmac_pkg::num_mul-1:0] rs2ex_uop_data,
  input  logic                                                  rs2ex_fifo_empty,
  input  logic                                                  rs2ex_fifo_1left_to_empty,
  output logic [rvv_mulmac_pkg::num_mul-1:0]                    ex2rs_fifo_pop,
  rvv_mulmac_if.src                                             rs2mul,
  rvv_mulmac_if.src                                             rs2mac
);

  logic [rvv_mulmac_pkg::num_mul-1:0] slot_valid;
  logic [rvv_mulmac_pkg::num_mul-1:0] slot_is_mac;
  logic [rvv_mulmac_pkg::num_mul-1:0] slot_ready;
  logic                               mac_first;
  logic                               slot1_go;

  // Two entries visible unless the FIFO is empty or down to one
  assign slot_valid[0] = !rs2ex_fifo_empty;
  assign slot_valid[1] = !(rs2ex_fifo_empty || rs2ex_fifo_1left_to_empty);

  assign slot_is_mac[0] = slot_valid[0] && rvv_mulmac_pkg::is_mac(rs2ex_uop_data[0].funct6);
  assign slot_is_mac[1] = slot_valid[1] && rvv_mulmac_pkg::is_mac(rs2ex_uop_data[1].funct6);

  // Routing table
  //   slot0 MUL, slot1 MUL : slot1 held
  //   slot0 MUL, slot1 MAC : straight
  //   slot0 MAC, slot1 MUL : swapped
  //   slot0 MAC, slot1 MAC : slot1 held
  always_comb begin
    mac_first = 1'b0;
    slot1_go  = 1'b0;
    case ({slot_is_mac[1], slot_is_mac[0]})
      2'b10: begin
        slot1_go = 1'b1;
      end
      2'b01: begin
        mac_first = 1'b1;
        slot1_go  = slot_valid[1];
      end
      2'b11: begin
        mac_first = 1'b1;
      end
      default: begin
        slot1_go = 1'b0;
      end
    endcase
  end

  assign slot_ready[0] = mac_first ? rs2mac.ready : rs2mul.ready;
  assign slot_ready[1] = mac_first ? rs2mul.ready : rs2mac.ready;

  // Slot 1 never leaves ahead of slot 0
  assign ex2rs_fifo_pop[0] = slot_valid[0] && slot_ready[0];
  assign ex2rs_fifo_pop[1] = slot1_go && slot_ready[1] && ex2rs_fifo_pop[0];

  // Slot 1 is offered only together with a slot 0 pop so that
  // every unit transfer matches exactly one FIFO pop
  assign rs2mul.valid = mac_first ? (slot1_go && ex2rs_fifo_pop[0]) : slot_valid[0];
  assign rs2mul.data  = mac_first ? rs2ex_uop_data[1] : rs2ex_uop_data[0];

  assign rs2mac.valid = mac_first ? slot_valid[0] : (slot1_go && ex2rs_fifo_pop[0]);
  assign rs2mac.data  = mac_first ? rs2ex_uop_data[0] : rs2ex_uop_data[1];

endmodule

`default_nettype wire

//--- rvv_mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_mul_unit (
  input  logic      clk,
  input  logic      rst_n,
  rvv_mulmac_if.dst in,
  rvv_mulmac_if.src out
);

  localparam int sew       = rvv_mulmac_pkg::sew;
  localparam int num_lanes = rvv_mulmac_pkg::num_lanes;

  rvv_mulmac_pkg::mul_rs_t       uop;
  logic [rvv_mulmac_pkg::vlen-1:0] lane_result;
  logic                          take;
  logic                          out_valid;
  rvv_mulmac_pkg::pu2rob_t       out_data;

  assign uop = in.data;

  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      lane_result[i*sew +: sew] = rvv_mulmac_pkg::mul_lane(uop.funct6,
                                                           uop.vs1_data[i*sew +: sew],
                                                           uop.vs2_data[i*sew +: sew]);
    end
  end

  // Accept when the output slot is free or drains this cycle
  assign in.ready = !out_valid || out.ready;
  assign take     = in.valid && in.ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out_data  <= '0;
    end else begin
      if (in.ready) begin
        out_valid <= in.valid;
      end
      if (take) begin
        out_data.rob_idx <= uop.rob_idx;
        out_data.w_data  <= lane_result;
      end
    end
  end

  assign out.valid = out_valid;
  assign out.data  = out_data;

endmodule

`default_nettype wire

//--- rvv_mac_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_mac_unit (
  input  logic      clk,
  input  logic      rst_n,
  rvv_mulmac_if.dst in,
  rvv_mulmac_if.src out
);

  localparam int sew       = rvv_mulmac_pkg::sew;
  localparam int num_lanes = rvv_mulmac_pkg::num_lanes;
  localparam int vlen      = rvv_mulmac_pkg::vlen;

  rvv_mulmac_pkg::mul_rs_t                     uop;
  logic [vlen-1:0]                             prod_next;
  logic [vlen-1:0]                             addend_next;
  logic [vlen-1:0]                             sum_next;
  logic                                        advance;

  // Stage 1 holds products and addends
  logic                                        s1_valid;
  logic [vlen-1:0]                             s1_prod;
  logic [vlen-1:0]                             s1_addend;
  logic [rvv_mulmac_pkg::funct6_width-1:0]     s1_funct6;
  logic [rvv_mulmac_pkg::rob_idx_width-1:0]    s1_rob_idx;

  // Stage 2 is the output register toward the ROB
  logic                                        s2_valid;
  rvv_mulmac_pkg::pu2rob_t                     s2_data;

  assign uop = in.data;

  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      prod_next[i*sew +: sew] = rvv_mulmac_pkg::mac_product_lane(uop.funct6,
                                                                 uop.vs1_data[i*sew +: sew],
                                                                 uop.vs2_data[i*sew +: sew],
                                                                 uop.vd_data[i*sew +: sew]);
      addend_next[i*sew +: sew] = rvv_mulmac_pkg::mac_addend_lane(uop.funct6,
                                                                  uop.vs2_data[i*sew +: sew],
                                                                  uop.vd_data[i*sew +: sew]);
    end
  end

  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      sum_next[i*sew +: sew] = rvv_mulmac_pkg::mac_accum_lane(s1_funct6,
                                                              s1_prod[i*sew +: sew],
                                                              s1_addend[i*sew +: sew]);
    end
  end

  // Whole pipe freezes while a result waits on the ROB
  assign advance  = !s2_valid || out.ready;
  assign in.ready = advance;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= in.valid;
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance && in.valid) begin
      s1_prod    <= prod_next;
      s1_addend  <= addend_next;
      s1_funct6  <= uop.funct6;
      s1_rob_idx <= uop.rob_idx;
    end
    if (advance && s1_valid) begin
      s2_data.rob_idx <= s1_rob_idx;
      s2_data.w_data  <= sum_next;
    end
  end

  assign out.valid = s2_valid;
  assign out.data  = s2_data;

endmodule

`default_nettype wire

//--- rvv_mulmac.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_mulmac (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  rvv_mulmac_pkg::mul_rs_t [rvv_mulmac_pkg::num_mul-1:0] rs2ex_uop_data,
  input  logic                                                  rs2ex_fifo_empty,
  input  logic                                                  rs2ex_fifo_1left_to_empty,
  output logic [rvv_mulmac_pkg::num_mul-1:0]                    ex2rs_fifo_pop,
  output logic [rvv_mulmac_pkg::num_mul-1:0]                    ex2rob_valid,
  output rvv_mulmac_pkg::pu2rob_t [rvv_mulmac_pkg::num_mul-1:0] ex2rob_data,
  input  logic [rvv_mulmac_pkg::num_mul-1:0]                    rob2ex_ready
);

  rvv_mulmac_if #(.payload_t(rvv_mulmac_pkg::mul_rs_t)) rs2mul ();
  rvv_mulmac_if #(.payload_t(rvv_mulmac_pkg::mul_rs_t)) rs2mac ();
  rvv_mulmac_if #(.payload_t(rvv_mulmac_pkg::pu2rob_t)) mul2rob ();
  rvv_mulmac_if #(.payload_t(rvv_mulmac_pkg::pu2rob_t)) mac2rob ();

  rvv_mulmac_dispatch u_dispatch (
    .rs2ex_uop_data            (rs2ex_uop_data),
    .rs2ex_fifo_empty          (rs2ex_fifo_empty),
    .rs2ex_fifo_1left_to_empty (rs2ex_fifo_1left_to_empty),
    .ex2rs_fifo_pop            (ex2rs_fifo_pop),
    .rs2mul                    (rs2mul),
    .rs2mac                    (rs2mac)
  );

  rvv_mul_unit u_mul (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (rs2mul),
    .out   (mul2rob)
  );

  rvv_mac_unit u_mac (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (rs2mac),
    .out   (mac2rob)
  );

  // Port 0 carries MUL results, port 1 MAC results
  assign ex2rob_valid[0] = mul2rob.valid;
  assign ex2rob_data[0]  = mul2rob.data;
  assign mul2rob.ready   = rob2ex_ready[0];

  assign ex2rob_valid[1] = mac2rob.valid;
  assign ex2rob_data[1]  = mac2rob.data;
  assign mac2rob.ready   = rob2ex_ready[1];

endmodule

`default_nettype wire

//--- rvv_mulmac_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_mulmac_assertions (
  input logic                                                  clk,
  input logic                                                  rst_n,
  input logic                                                  rs2ex_fifo_empty,
  input logic [rvv_mulmac_pkg::num_mul-1:0]                    ex2rs_fifo_pop,
  input logic [rvv_mulmac_pkg::num_mul-1:0]                    ex2rob_valid,
  input rvv_mulmac_pkg::pu2rob_t [rvv_mulmac_pkg::num_mul-1:0] ex2rob_data,
  input logic [rvv_mulmac_pkg::num_mul-1:0]                    rob2ex_ready
);

  // In-order pops from the station
  a_pop_order: assert property (@(posedge clk) disable iff (!rst_n)
    ex2rs_fifo_pop[1] |-> ex2rs_fifo_pop[0])
    else $error("pop[1] asserted without pop[0]");

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    rs2ex_fifo_empty |-> (ex2rs_fifo_pop == 2'b00))
    else $error("pop asserted while the FIFO is empty");

  // Results held until the ROB takes them
  a_mul_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (ex2rob_valid[0] && !rob2ex_ready[0]) |=> (ex2rob_valid[0] && $stable(ex2rob_data[0])))
    else $error("MUL result dropped or changed before ready");

  a_mac_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (ex2rob_valid[1] && !rob2ex_ready[1]) |=> (ex2rob_valid[1] && $stable(ex2rob_data[1])))
    else $error("MAC result dropped or changed before ready");

  a_reset_idle: assert property (@(posedge clk)
    !rst_n |=> (ex2rob_valid == 2'b00))
    else $error("ex2rob_valid high right after reset");

endmodule

bind rvv_mulmac rvv_mulmac_assertions u_assertions (
  .clk              (clk),
  .rst_n            (rst_n),
  .rs2ex_fifo_empty (rs2ex_fifo_empty),
  .ex2rs_fifo_pop   (ex2rs_fifo_pop),
  .ex2rob_valid     (ex2rob_valid),
  .ex2rob_data      (ex2rob_data),
  .rob2ex_ready     (rob2ex_ready)
);

`default_nettype wire

//--- tb_rvv_mulmac.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rvv_mulmac;

  localparam int num_uops     = 300;
  localparam int clk_period   = 8;
  localparam int sample_delay = clk_period / 2 - 1;

  logic                                                  clk = 1'b0;
  logic                                                  rst_n;
  rvv_mulmac_pkg::mul_rs_t [rvv_mulmac_pkg::num_mul-1:0] rs2ex_uop_data;
  logic                                                  rs2ex_fifo_empty;
  logic                                                  rs2ex_fifo_1left_to_empty;
  logic [rvv_mulmac_pkg::num_mul-1:0]                    ex2rs_fifo_pop;
  logic [rvv_mulmac_pkg::num_mul-1:0]                    ex2rob_valid;
  rvv_mulmac_pkg::pu2rob_t [rvv_mulmac_pkg::num_mul-1:0] ex2rob_data;
  logic [rvv_mulmac_pkg::num_mul-1:0]                    rob2ex_ready;

  // Station entries and per-port expected results
  rvv_mulmac_pkg::mul_rs_t station [$];
  rvv_mulmac_pkg::pu2rob_t exp_mul [$];
  rvv_mulmac_pkg::pu2rob_t exp_mac [$];
  logic [31:0]             lcg_state;
  int                      errors = 0;
  int                      gen_count = 0;
  int                      gen_mul = 0;
  int                      popped = 0;
  int                      returned_mul = 0;
  int                      returned_mac = 0;

  always #(clk_period / 2) clk = ~clk;

  rvv_mulmac UUT (
    .clk                       (clk),
    .rst_n                     (rst_n),
    .rs2ex_uop_data            (rs2ex_uop_data),
    .rs2ex_fifo_empty          (rs2ex_fifo_empty),
    .rs2ex_fifo_1left_to_empty (rs2ex_fifo_1left_to_empty),
    .ex2rs_fifo_pop            (ex2rs_fifo_pop),
    .ex2rob_valid              (ex2rob_valid),
    .ex2rob_data               (ex2rob_data),
    .rob2ex_ready              (rob2ex_ready)
  );

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [5:0] random_funct6();
    case ((next_random() >> 16) % 32'd7)
      0: return rvv_mulmac_pkg::VMUL;
      1: return rvv_mulmac_pkg::VMULH;
      2: return rvv_mulmac_pkg::VMULHU;
      3: return rvv_mulmac_pkg::VMACC;
      4: return rvv_mulmac_pkg::VNMSAC;
      5: return rvv_mulmac_pkg::VMADD;
      default: return rvv_mulmac_pkg::VNMSUB;
    endcase
  endfunction

  function automatic rvv_mulmac_pkg::mul_rs_t random_uop(input logic [3:0] idx);
    rvv_mulmac_pkg::mul_rs_t u;
    u.funct6   = random_funct6();
    u.vs1_data = {next_random(), next_random()};
    u.vs2_data = {next_random(), next_random()};
    u.vd_data  = {next_random(), next_random()};
    u.rob_idx  = idx;
    return u;
  endfunction

  // Lane arithmetic at SEW 16, products wrap to the low half unless a high form
  function automatic rvv_mulmac_pkg::pu2rob_t expected_result(
      input rvv_mulmac_pkg::mul_rs_t u);
    rvv_mulmac_pkg::pu2rob_t r;
    logic [15:0]             a, b, d, res;
    logic [31:0]             ps, pu;
    r.rob_idx = u.rob_idx;
    r.w_data  = '0;
    for (int i = 0; i < 4; i++) begin
      a  = u.vs1_data[i*16 +: 16];
      b  = u.vs2_data[i*16 +: 16];
      d  = u.vd_data[i*16 +: 16];
      ps = $signed({{16{a[15]}}, a}) * $signed({{16{b[15]}}, b});
      pu = {16'h0000, a} * {16'h0000, b};
      case (u.funct6)
        rvv_mulmac_pkg::VMUL:   res = pu[15:0];
        rvv_mulmac_pkg::VMULH:  res = ps[31:16];
        rvv_mulmac_pkg::VMULHU: res = pu[31:16];
        rvv_mulmac_pkg::VMACC:  res = d + a * b;
        rvv_mulmac_pkg::VNMSAC: res = d - a * b;
        rvv_mulmac_pkg::VMADD:  res = a * d + b;
        default:                res = b - a * d;
      endcase
      r.w_data[i*16 +: 16] = res;
    end
    return r;
  endfunction

  task automatic check_result(input string name, input rvv_mulmac_pkg::pu2rob_t exp_val,
                              input rvv_mulmac_pkg::pu2rob_t act_val);
    if (exp_val !== act_val) begin
      errors++;
      $display("ERR %s exp=%h act=%h", name, exp_val, act_val);
    end
  endtask

  task automatic check_count(input string name, input int exp_val, input int act_val);
    if (exp_val != act_val) begin
      errors++;
      $display("ERR %s exp=%h act=%h", name, exp_val, act_val);
    end
  endtask

  // Pops allowed by the station depth, and slot 1 only with slot 0
  task automatic check_pop(input logic [1:0] pop, input int depth);
    logic [1:0] allowed;
    allowed = (depth == 0) ? 2'b00 : ((depth == 1) ? 2'b01 : 2'b11);
    if ((pop & ~allowed) != 2'b00) begin
      errors++;
      $display("ERR ex2rs_fifo_pop allowed=%h act=%h", allowed, pop);
    end
    if (pop[1] && !pop[0]) begin
      errors++;
      $display("Station popped slot 1 while slot 0 stayed in the FIFO");
    end
  endtask

  task automatic record_pop();
    rvv_mulmac_pkg::mul_rs_t u;
    u = station.pop_front();
    if (rvv_mulmac_pkg::is_mac(u.funct6)) begin
      exp_mac.push_back(expected_result(u));
    end else begin
      exp_mul.push_back(expected_result(u));
    end
  endtask

  initial begin : stimulus
    int         n_new;
    logic [1:0] pop;
    lcg_state                 = 32'd76;
    rst_n                     = 1'b0;
    rs2ex_uop_data            = '0;
    rs2ex_fifo_empty          = 1'b1;
    rs2ex_fifo_1left_to_empty = 1'b0;
    rob2ex_ready              = 2'b00;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    while (!(gen_count == num_uops && station.size() == 0 &&
             exp_mul.size() == 0 && exp_mac.size() == 0)) begin
      // Zero to two arrivals per cycle keep the FIFO depth moving
      n_new = int'((next_random() >> 16) % 32'd3);
      for (int k = 0; k < n_new && gen_count < num_uops; k++) begin
        station.push_back(random_uop(gen_count[3:0]));
        if (!rvv_mulmac_pkg::is_mac(station[station.size()-1].funct6)) begin
          gen_mul++;
        end
        gen_count++;
      end
      rs2ex_fifo_empty          = (station.size() == 0);
      rs2ex_fifo_1left_to_empty = (station.size() == 1);
      rs2ex_uop_data[0]         = (station.size() > 0) ? station[0] : '0;
      rs2ex_uop_data[1]         = (station.size() > 1) ? station[1] : '0;
      rob2ex_ready[0]           = ((next_random() >> 16) % 32'd10) < 32'd7;
      rob2ex_ready[1]           = ((next_random() >> 16) % 32'd10) < 32'd7;
      #(sample_delay);
      pop = ex2rs_fifo_pop;
      check_pop(pop, station.size());
      // Every pop the DUT raised, whatever the model still holds
      popped += int'(pop[0]) + int'(pop[1]);
      if (pop[0] && station.size() > 0) begin
        record_pop();
      end
      if (pop[1] && station.size() > 0) begin
        record_pop();
      end
      @(negedge clk);
    end
    check_count("popped", num_uops, popped);
    check_count("returned", num_uops, returned_mul + returned_mac);
    check_count("returned_mul", gen_mul, returned_mul);
    $display("Done: errors=%0d popped=%0d mul=%0d mac=%0d",
             errors, popped, returned_mul, returned_mac);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Result transfers sampled just before the rising edge
  always @(negedge clk) begin : compare
    rvv_mulmac_pkg::pu2rob_t expected;
    #(sample_delay);
    if (rst_n && ex2rob_valid[0] && rob2ex_ready[0]) begin
      returned_mul++;
      if (exp_mul.size() == 0) begin
        errors++;
        $display("MUL port returned a result with no micro-op outstanding");
      end else begin
        expected = exp_mul.pop_front();
        check_result("ex2rob_data[0]", expected, ex2rob_data[0]);
      end
    end
    if (rst_n && ex2rob_valid[1] && rob2ex_ready[1]) begin
      returned_mac++;
      if (exp_mac.size() == 0) begin
        errors++;
        $display("MAC port returned a result with no micro-op outstanding");
      end else begin
        expected = exp_mac.pop_front();
        check_result("ex2rob_data[1]", expected, ex2rob_data[1]);
      end
    end
  end

  initial begin : watchdog
    #(num_uops * 20 * clk_period);
    $display("Timeout: not all micro-ops popped and returned in time");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- rvv_mulmac.f
rvv_mulmac_pkg.sv
rvv_mulmac_if.sv
rvv_mulmac_dispatch.sv
rvv_mul_unit.sv
rvv_mac_unit.sv
rvv_mulmac.sv
rvv_mulmac_assertions.sv
tb_rvv_mulmac.sv

//--- Makefile
TOP := tb_rvv_mulmac

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f rvv_mulmac.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f rvv_mulmac.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
